//--- source/sync_pkg.sv
package sync_pkg;

  // settings handed from the register block to the time base.
  typedef struct packed {
    logic        update;          // one-cycle strobe that arms a time load.
    logic [63:0] ecat_sync_time;  // distributed-clock time of the next SYNC0 in ns.
  } sync_settings_t;

  // register stages inside pipe_add_sub.
  localparam int add_sub_latency = 6;

  // register stages inside the ns to tick converter.
  localparam int conv_latency = 4;

  // 0.01024 ticks per ns scaled by 2**32.
  localparam logic [31:0] ec_to_sys_mult = 32'd43980465;

  // register port addresses.
  localparam logic [1:0] reg_time_lo = 2'd0;
  localparam logic [1:0] reg_time_hi = 2'd1;
  localparam logic [1:0] reg_ctrl    = 2'd2;

endpackage

//--- source/sync_settings_regs.sv
`timescale 1ns/1ps
module sync_settings_regs (
  input  logic                     CLK,
  input  logic                     rst_n,
  input  logic                     wr_en,
  input  logic [1:0]               wr_addr,
  input  logic [31:0]              wr_data,
  output sync_pkg::sync_settings_t settings
);
  import sync_pkg::*;

  logic [31:0] time_lo;
  logic [31:0] time_hi;
  logic        arm_write;
  logic        update;

  // bit 0 of the control register requests a load at the next SYNC0.
  assign arm_write = wr_en && (wr_addr == reg_ctrl) && wr_data[0];

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      case (wr_addr)
        reg_time_lo: time_lo <= wr_data;
        reg_time_hi: time_hi <= wr_data;
        default: ;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      update <= 1'b0;
    end else begin
      update <= arm_write;
    end
  end

  assign settings.update         = update;
  assign settings.ecat_sync_time = {time_hi, time_lo};

  a_update_single : assert property (
    @(posedge CLK) disable iff (!rst_n) settings.update |=> !settings.update
  ) else $error("update strobe held for more than one cycle");

endmodule

//--- source/ec_time_to_sys_time.sv
`timescale 1ns/1ps
module ec_time_to_sys_time (
  input  logic        CLK,
  input  logic        rst_n,
  input  logic [63:0] ec_time,
  output logic [63:0] sys_time
);
  import sync_pkg::*;

  // three arithmetic stages, the rest is plain delay.
  localparam int tail_stages = conv_latency - 3;

  logic [3:0][47:0]             pp;
  logic [63:0]                  lo_sum;
  logic [63:0]                  hi_sum;
  logic [95:0]                  product;
  logic [tail_stages-1:0][63:0] tail;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      pp      <= '0;
      lo_sum  <= '0;
      hi_sum  <= '0;
      product <= '0;
      tail    <= '0;
    end else begin
      // 16-bit slices of the ns time against the full constant.
      for (int i = 0; i < 4; i++) begin
        pp[i] <= ec_time[16*i +: 16] * ec_to_sys_mult;
      end

      lo_sum <= {16'd0, pp[0]} + {pp[1], 16'd0};
      hi_sum <= {16'd0, pp[2]} + {pp[3], 16'd0};  // weighted by 2**32.

      product <= {32'd0, lo_sum} + {hi_sum, 32'd0};

      tail[0] <= product[95:32];  // drop the fraction.
      for (int i = 1; i < tail_stages; i++) begin
        tail[i] <= tail[i-1];
      end
    end
  end

  assign sys_time = tail[tail_stages-1];

endmodule

//--- source/pipe_add_sub.sv
`timescale 1ns/1ps
module pipe_add_sub #(
  parameter bit subtract = 1'b0
) (
  input  logic               CLK,
  input  logic               rst_n,
  input  logic [63:0]        a,
  input  logic [63:0]        b,
  output logic signed [64:0] s
);
  import sync_pkg::*;

  logic signed [64:0]               a_ext;
  logic signed [64:0]               b_ext;
  logic signed [64:0]               result;
  logic [add_sub_latency-1:0][64:0] stage;

  assign a_ext = {1'b0, a};
  assign b_ext = {1'b0, b};

  if (subtract) begin : g_sub
    assign result = a_ext - b_ext;
  end else begin : g_add
    assign result = a_ext + b_ext;
  end

  // every cycle's operands leave the chain add_sub_latency cycles later.
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      stage <= '0;
    end else begin
      stage[0] <= result;
      for (int i = 1; i < add_sub_latency; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign s = stage[add_sub_latency-1];

endmodule

//--- source/synchronizer.sv
`timescale 1ns/1ps
module synchronizer #(
  parameter int sync_period = 5120
) (
  input  logic                     CLK,
  input  logic                     rst_n,
  input  sync_pkg::sync_settings_t settings,
  input  logic [63:0]              ecat_time_conv,
  input  logic                     ecat_sync,
  output logic [63:0]              sys_time,
  output logic                     sync,
  output logic                     skip_one_assert
);
  import sync_pkg::*;

  localparam int cnt_w    = $clog2(add_sub_latency + 2);
  localparam int wait_w   = $clog2(conv_latency + 1);
  localparam int period_w = $clog2(sync_period);

  localparam logic [cnt_w-1:0]    lat_done     = cnt_w'(add_sub_latency);
  localparam logic [cnt_w-1:0]    lat_idle     = cnt_w'(add_sub_latency + 1);
  localparam logic [period_w-1:0] half_period  = period_w'(sync_period / 2);
  localparam logic [period_w-1:0] last_period  = period_w'(sync_period - 1);
  localparam logic [63:0]         period_ticks = 64'(sync_period);

  logic [2:0]          sync_tri;
  logic                armed;
  logic [wait_w-1:0]   wait_cnt;
  logic                load;
  logic                locked;
  logic [63:0]         sys_time_inc;
  logic [63:0]         next_sync_time;
  logic signed [64:0]  s_diff;
  logic signed [64:0]  s_next;
  logic signed [18:0]  sync_time_diff;
  logic [cnt_w-1:0]    diff_cnt;
  logic [cnt_w-1:0]    next_cnt;
  logic [period_w-1:0] period_cnt;

  assign sync = sync_tri[1] & ~sync_tri[2];  // rising edge seen in the two older flops.
  assign load = sync & armed & (wait_cnt == '0) & ~settings.update;
  assign sys_time_inc = sys_time + 64'd1;

  // error is the predicted time minus the value the counter takes after this cycle.
  pipe_add_sub #(
    .subtract(1'b1)
  ) sub_diff (
    .CLK  (CLK),
    .rst_n(rst_n),
    .a    (next_sync_time),
    .b    (sys_time_inc),
    .s    (s_diff)
  );

  pipe_add_sub #(
    .subtract(1'b0)
  ) add_next (
    .CLK  (CLK),
    .rst_n(rst_n),
    .a    (next_sync_time),
    .b    (period_ticks),
    .s    (s_next)
  );

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      sync_tri <= '0;
    end else begin
      sync_tri <= {sync_tri[1:0], ecat_sync};
    end
  end

  // the converted time settles conv_latency cycles after an update.
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      armed    <= 1'b0;
      wait_cnt <= '0;
    end else if (settings.update) begin
      armed    <= 1'b1;
      wait_cnt <= wait_w'(conv_latency - 1);
    end else begin
      if (load) begin
        armed <= 1'b0;
      end
      if (wait_cnt != '0) begin
        wait_cnt <= wait_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      sys_time        <= '0;
      skip_one_assert <= 1'b0;
      sync_time_diff  <= '0;
      diff_cnt        <= lat_idle;
      locked          <= 1'b0;
    end else if (load) begin
      sys_time        <= ecat_time_conv;
      skip_one_assert <= 1'b0;
      sync_time_diff  <= '0;  // drops any correction still pending.
      diff_cnt        <= lat_idle;
      locked          <= 1'b1;
    end else if (sync) begin
      sys_time        <= sys_time_inc;
      skip_one_assert <= 1'b0;
      if (locked) begin
        diff_cnt <= cnt_w'(1);  // no prediction exists before the first load.
      end
    end else if (diff_cnt == lat_done) begin
      sys_time        <= sys_time_inc;
      skip_one_assert <= 1'b0;
      sync_time_diff  <= {s_diff[64], s_diff[17:0]};
      diff_cnt        <= lat_idle;
    end else if (diff_cnt != lat_idle) begin
      sys_time        <= sys_time_inc;
      skip_one_assert <= 1'b0;
      diff_cnt        <= diff_cnt + 1'b1;
    end else if (sync_time_diff > 19'sd0) begin
      sys_time        <= sys_time + 64'd2;  // counter is behind.
      skip_one_assert <= 1'b1;
      sync_time_diff  <= sync_time_diff - 19'sd1;
    end else if (sync_time_diff < 19'sd0) begin
      skip_one_assert <= 1'b0;  // counter is ahead so it holds.
      sync_time_diff  <= sync_time_diff + 19'sd1;
    end else begin
      sys_time        <= sys_time_inc;
      skip_one_assert <= 1'b0;
    end
  end

  // the next prediction is launched halfway between pulses.
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      next_sync_time <= '0;
      next_cnt       <= lat_idle;
      period_cnt     <= half_period;
    end else if (load) begin
      next_sync_time <= ecat_time_conv;
      next_cnt       <= lat_idle;
      period_cnt     <= half_period;
    end else begin
      if (sync) begin
        period_cnt <= half_period;
      end else if (period_cnt == last_period) begin
        period_cnt <= '0;
      end else begin
        period_cnt <= period_cnt + 1'b1;
      end

      if (!sync && period_cnt == last_period) begin
        next_cnt <= cnt_w'(1);
      end else if (next_cnt == lat_done) begin
        next_sync_time <= s_next[63:0];
        next_cnt       <= lat_idle;
      end else if (next_cnt != lat_idle) begin
        next_cnt <= next_cnt + 1'b1;
      end
    end
  end

  // the captured error has to fit the 19-bit correction register.
  a_diff_range : assert property (
    @(posedge CLK) disable iff (!rst_n)
    (!load && !sync && diff_cnt == lat_done)
      |-> (s_diff[64:18] == '0 || s_diff[64:18] == '1)
  ) else $error("sync error too large for the correction register");

  a_pred_ready : assert property (
    @(posedge CLK) disable iff (!rst_n)
    (sync && locked && !load) |-> next_cnt == lat_idle
  ) else $error("sync pulse while the next prediction is still in flight");

endmodule

//--- source/time_sync_top.sv
`timescale 1ns/1ps
module time_sync_top #(
  parameter int sync_period = 5120
) (
  input  logic        CLK,
  input  logic        rst_n,
  input  logic        wr_en,
  input  logic [1:0]  wr_addr,
  input  logic [31:0] wr_data,
  input  logic        ecat_sync,
  output logic [63:0] sys_time,
  output logic        sync,
  output logic        skip_one_assert
);
  import sync_pkg::*;

  sync_settings_t settings;
  logic [63:0]    ecat_time_conv;

  sync_settings_regs sync_settings_regs_i (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .settings(settings)
  );

  // the converter runs continuously on the registered sync time.
  ec_time_to_sys_time ec_time_to_sys_time_i (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .ec_time (settings.ecat_sync_time),
    .sys_time(ecat_time_conv)
  );

  synchronizer #(
    .sync_period(sync_period)
  ) synchronizer_i (
    .CLK            (CLK),
    .rst_n          (rst_n),
    .settings       (settings),
    .ecat_time_conv (ecat_time_conv),
    .ecat_sync      (ecat_sync),
    .sys_time       (sys_time),
    .sync           (sync),
    .skip_one_assert(skip_one_assert)
  );

endmodule

//--- bench/clock_gen.sv
`timescale 1ns/1ps
module clock_gen #(
  parameter int period_ns    = 8,
  parameter int reset_cycles = 8
) (
  output logic CLK,
  output logic rst_n
);

  initial begin
    CLK = 1'b0;
    forever #(period_ns / 2) CLK = ~CLK;
  end

  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge CLK);
    #1 rst_n = 1'b1;  // released in the drive slot like every other input.
  end

endmodule

//--- bench/tb_time_sync.sv
`timescale 1ns/1ps
module tb_time_sync;
  import sync_pkg::*;

  localparam int sync_period = 256;
  localparam int num_tests   = 6;
  localparam int watchdog_ns = 12 * sync_period * 8 * num_tests + 4000;
  localparam logic [95:0] ticks_per_ns_q32 = 96'd43980465;  // 0.01024 * 2**32.

  logic CLK, rst_n, wr_en, ecat_sync, sync, skip_one_assert;
  logic [1:0] wr_addr;
  logic [31:0] wr_data;
  logic [63:0] sys_time, ns;
  integer seed;
  int errors, test_start, tests_passed, tests_failed, sync_count, c0, d;
  int holds, skips, bad_skips, singles;
  int unsigned cyc, last_pulse;
  // reference model state.
  logic m_prev_es, m_rise_d1, m_sync, m_upd_q, m_armed, m_locked, m_skip;
  logic pulse_now, update_now, do_load;
  logic [63:0] m_time_ns, m_sys, m_base;
  int unsigned m_upd_edge;
  int m_pulses, m_meas_cnt;
  longint m_pending, m_err;

  clock_gen clock_gen_i (.CLK(CLK), .rst_n(rst_n));

  time_sync_top #(.sync_period(sync_period)) time_sync_top_i (
    .CLK(CLK), .rst_n(rst_n), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .ecat_sync(ecat_sync), .sys_time(sys_time), .sync(sync),
    .skip_one_assert(skip_one_assert)
  );

  function automatic logic [63:0] ns_to_ticks(input logic [63:0] t);
    logic [95:0] product;
    product = {32'd0, t} * ticks_per_ns_q32;
    return product[95:32];  // fraction is truncated.
  endfunction

  task automatic report_fail(input string msg);
    $display("FAIL %0d ns: %s", $time, msg);
    errors++;
  endtask

  always @(posedge CLK) begin
    cyc = cyc + 1;
    if (!rst_n) begin
      {m_prev_es, m_rise_d1, m_sync, m_upd_q, m_armed, m_locked, m_skip} = '0;
      m_sys = '0;
      m_err = 0;
      m_meas_cnt = 0;
    end else begin
      pulse_now  = m_sync;
      update_now = m_upd_q;
      do_load = pulse_now && m_armed && !update_now && (cyc - m_upd_edge >= conv_latency);
      if (do_load) begin
        m_sys = ns_to_ticks(m_time_ns);
        m_base = m_sys;  // predictions restart from the loaded time.
        {m_pulses, m_meas_cnt, m_err, m_skip, m_armed, m_locked} = {32'd0, 32'd0, 64'd0, 3'b001};
      end else if (pulse_now) begin
        m_sys = m_sys + 64'd1;
        m_skip = 1'b0;
        if (m_locked) begin
          m_pulses++;
          m_pending = $signed(m_base + 64'(m_pulses * sync_period) - m_sys);
          m_meas_cnt = add_sub_latency;
        end
      end else if (m_meas_cnt != 0) begin
        m_sys = m_sys + 64'd1;
        m_skip = 1'b0;
        if (m_meas_cnt == 1) m_err = m_pending;
        m_meas_cnt--;
      end else if (m_err > 0) begin
        m_sys = m_sys + 64'd2;
        m_skip = 1'b1;
        m_err--;
      end else if (m_err < 0) begin
        m_skip = 1'b0;  // counter holds.
        m_err++;
      end else begin
        m_sys = m_sys + 64'd1;
        m_skip = 1'b0;
      end
      if (update_now) begin
        m_armed = 1'b1;
        m_upd_edge = cyc;
      end
      m_upd_q = wr_en && (wr_addr == reg_ctrl) && wr_data[0];
      if (wr_en && wr_addr == reg_time_lo) m_time_ns[31:0] = wr_data;
      if (wr_en && wr_addr == reg_time_hi) m_time_ns[63:32] = wr_data;
      m_sync = m_rise_d1;  // pulse follows the sampling edge by one more edge.
      m_rise_d1 = ecat_sync && !m_prev_es;
      m_prev_es = ecat_sync;
    end
  end

  always @(negedge CLK) begin
    if (rst_n) begin
      if (sync) sync_count++;
      assert (sys_time == m_sys)
        else report_fail($sformatf("sys_time %0d, model %0d", sys_time, m_sys));
      assert (sync == m_sync) else report_fail($sformatf("sync %0b, model %0b", sync, m_sync));
      assert (skip_one_assert == m_skip)
        else report_fail($sformatf("skip flag %0b, model %0b", skip_one_assert, m_skip));
    end
  end

  task automatic drive_slot();
    @(posedge CLK);
    #1;
  endtask

  task automatic reg_write(input logic [1:0] addr, input logic [31:0] data);
    wr_en = 1'b1;
    wr_addr = addr;
    wr_data = data;
    drive_slot();
    wr_en = 1'b0;
  endtask

  task automatic load_time(input logic [63:0] t);
    drive_slot();
    reg_write(reg_time_lo, t[31:0]);
    reg_write(reg_time_hi, t[63:32]);
    reg_write(reg_ctrl, 32'd1);
  endtask

  // raises SYNC0 so that the synchronised pulse acts at edge target.
  task automatic pulse_at(input int unsigned target);
    int waited;
    drive_slot();
    if (cyc + 3 > target) begin
      $display("SYNC0 edge for cycle %0d was requested too late", target);
      errors++;
    end
    while (cyc + 3 < target) drive_slot();
    ecat_sync = 1'b1;
    waited = 0;
    @(negedge CLK);
    while (!sync && waited < 10) begin
      @(negedge CLK);
      waited++;
    end
    if (!sync) begin
      $display("no sync pulse followed the SYNC0 edge raised at cycle %0d", target - 3);
      errors++;
    end else begin
      assert (cyc == target - 1)
        else report_fail($sformatf("sync pulse in cycle %0d, expected %0d", cyc, target - 1));
    end
    drive_slot();
    ecat_sync = 1'b0;
  endtask

  task automatic observe(input int cycles, output int n_hold, output int n_skip,
                         output int n_bad, output int n_single);
    logic [63:0] prev;
    {n_hold, n_skip, n_bad, n_single} = '0;
    @(negedge CLK);
    prev = sys_time;
    repeat (cycles) begin
      @(negedge CLK);
      if (sys_time == prev) n_hold++;
      if (sys_time == prev + 64'd1) n_single++;
      if (skip_one_assert) begin
        n_skip++;
        if (sys_time != prev + 64'd2) n_bad++;
      end
      prev = sys_time;
    end
  endtask

  task automatic finish_test(input int num, input string name);
    if (errors == test_start) begin
      tests_passed++;
      $display("test %0d %s: pass", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: fail with %0d errors", num, name, errors - test_start);
    end
    test_start = errors;
  endtask

  initial begin
    #(watchdog_ns);
    $display("run timed out after %0d ns before all tests finished", watchdog_ns);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    seed = 32'h699b_02b4;
    {errors, test_start, tests_passed, tests_failed, sync_count, cyc} = '0;
    wr_en = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    ecat_sync = 1'b0;
    wait (rst_n === 1'b1);

    @(negedge CLK);
    assert (sys_time == 64'd0 && !sync && !skip_one_assert)
      else report_fail("outputs not cleared by reset");
    observe(16, holds, skips, bad_skips, singles);
    assert (sync_count == 0 && skips == 0) else report_fail("sync or skip high before SYNC0");
    finish_test(1, "reset");

    c0 = sync_count;
    pulse_at(cyc + 8);
    observe(12, holds, skips, bad_skips, singles);
    assert (sync_count - c0 == 1) else report_fail("one SYNC0 edge gave several pulses");
    assert (singles == 12) else report_fail("sys_time did not step by one each cycle");
    finish_test(2, "sync pulse");

    ns = {$random(seed), $random(seed)};
    load_time(ns);
    pulse_at(cyc + 8);
    last_pulse = cyc;
    @(negedge CLK);
    assert (sys_time == ns_to_ticks(ns)) else report_fail("loaded time differs from conversion");
    finish_test(3, "time load");

    d = 1 + ($unsigned($random(seed)) % 40);
    pulse_at(last_pulse + sync_period + d);
    last_pulse = cyc;
    observe(60, holds, skips, bad_skips, singles);
    assert (holds == d && skips == 0)
      else report_fail($sformatf("late by %0d gave %0d holds, %0d skips", d, holds, skips));
    finish_test(4, "late pulse");

    d = 1 + ($unsigned($random(seed)) % 40);
    pulse_at(last_pulse + sync_period - d);
    last_pulse = cyc;
    observe(60, holds, skips, bad_skips, singles);
    assert (skips == d && bad_skips == 0 && holds == 0)
      else report_fail($sformatf("early by %0d gave %0d skips", d, skips));
    finish_test(5, "early pulse");

    d = 20 + ($unsigned($random(seed)) % 21);  // long enough to be pending at the reload.
    pulse_at(last_pulse + sync_period + d);
    ns = {$random(seed), $random(seed)};
    load_time(ns);
    pulse_at(cyc + 16);
    last_pulse = cyc;
    @(negedge CLK);
    assert (sys_time == ns_to_ticks(ns)) else report_fail("reloaded time differs from conversion");
    observe(50, holds, skips, bad_skips, singles);
    assert (holds == 0 && skips == 0) else report_fail("correction survived the reload");
    d = 1 + ($unsigned($random(seed)) % 40);
    pulse_at(last_pulse + sync_period - d);
    observe(60, holds, skips, bad_skips, singles);
    assert (skips == d && bad_skips == 0)
      else report_fail($sformatf("after reload early by %0d gave %0d skips", d, skips));
    finish_test(6, "re-arm");

    $display("%0d of %0d tests passed, %0d failed, %0d errors", tests_passed, num_tests,
             tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- time_sync.f
source/sync_pkg.sv
source/sync_settings_regs.sv
source/ec_time_to_sys_time.sv
source/pipe_add_sub.sv
source/synchronizer.sv
source/time_sync_top.sv
bench/clock_gen.sv
bench/tb_time_sync.sv

//--- Makefile
TOP := tb_time_sync
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
	  -Mdir obj_dir -f time_sync.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
	  echo "simulation reported a failure"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
